//--- flist.f
float_pkg.sv
fpu_op_pkg.sv
fpu_issue.sv
float_add_pipeline.sv
fpu_retire.sv
fpu_top.sv
fpu_tb.sv

//--- Makefile
# Verilator build and run of the FPU add testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build fpu_tb with Verilator, run it and search $(LOG) for the pass line"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module fpu_tb -o fpu_tb_sim
	./obj_dir/fpu_tb_sim | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- fpu_tb.sv
// expects a fixed 5-cycle latency and truncating arithmetic; table values are exact floats only
module fpu_tb
    import float_pkg::*;
    import fpu_op_pkg::*;
();

    localparam int num_vectors  = 16;
    localparam int reset_cycles = 8;
    localparam int latency      = 5;
    // reset plus worst-case gap, issue and drain for every entry
    localparam int cycle_limit  = 20 + 9 * num_vectors;

    typedef logic [float_width-1:0] word_t;

    // one table row, flags are {zero, negative, overflow, underflow}
    typedef struct packed {
        fpu_op_e    op;
        word_t      a;
        word_t      b;
        word_t      res;
        fpu_flags_t flags;
    } vector_t;

    logic     clk;
    logic     rst;
    fpu_req_t req;
    fpu_rsp_t rsp;

    vector_t vectors [num_vectors];
    int      seed;
    int      gap;
    int      errors;
    int      checks;
    int      responses;
    int      run_cycles;
    // outstanding requests, oldest at the front
    int                   due_q [$];
    logic [tag_width-1:0] tag_q [$];

    fpu_top dut_i (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp)
    );

    always #4 clk = ~clk;

    task automatic set_vector(input int idx, input fpu_op_e op, input word_t a,
                              input word_t b, input word_t res, input fpu_flags_t flags);
        vectors[idx] = '{op: op, a: a, b: b, res: res, flags: flags};
    endtask

    task automatic load_vectors();
        // same-sign add, carry renormalize, exponent alignment
        set_vector(0, op_add, 32'h3FC00000, 32'h40100000, 32'h40700000, 4'b0000);
        set_vector(1, op_add, 32'hBF800000, 32'hBF800000, 32'hC0000000, 4'b0100);
        set_vector(2, op_add, 32'h44800000, 32'h3F000000, 32'h44801000, 4'b0000);
        // opposite signs, left normalize and exact cancellation
        set_vector(3, op_sub, 32'h40A00000, 32'h40400000, 32'h40000000, 4'b0000);
        set_vector(4, op_sub, 32'h40400000, 32'h40A00000, 32'hC0000000, 4'b0100);
        set_vector(5, op_sub, 32'h3FC00000, 32'h3FC00000, 32'h00000000, 4'b1000);
        // 2^-24 lands in the guard bit and is dropped
        set_vector(6, op_add, 32'h3F800000, 32'h33800000, 32'h3F800000, 4'b0000);
        set_vector(7, op_sub, 32'h3F800000, 32'h33800000, 32'h3F7FFFFF, 4'b0000);
        // 24-place left shift after near cancellation
        set_vector(8, op_sub, 32'h3F800000, 32'h3F7FFFFF, 32'h33800000, 4'b0000);
        // overflow saturates to signed infinity
        set_vector(9, op_add, 32'h7F7FFFFF, 32'h7F7FFFFF, 32'h7F800000, 4'b0010);
        set_vector(10, op_add, 32'hFF7FFFFF, 32'hFF7FFFFF, 32'hFF800000, 4'b0110);
        // difference below the smallest normal flushes to signed zero
        set_vector(11, op_sub, 32'h01000000, 32'h00FFFFFF, 32'h00000000, 4'b1001);
        set_vector(12, op_sub, 32'h00800000, 32'h00800001, 32'h80000000, 4'b1101);
        // subnormal inputs act as zero
        set_vector(13, op_add, 32'h00400000, 32'h3F800000, 32'h3F800000, 4'b0000);
        set_vector(14, op_add, 32'h00400000, 32'h80400000, 32'h00000000, 4'b1000);
        set_vector(15, op_sub, 32'h40000000, 32'h3F000000, 32'h3FC00000, 4'b0000);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            req.valid = 1'b0;
        end
    endtask

    task automatic send_request(input int idx);
        @(negedge clk);
        req.valid = 1'b1;
        req.op    = vectors[idx].op;
        req.tag   = tag_width'(idx);
        req.a.raw = vectors[idx].a;
        req.b.raw = vectors[idx].b;
        // sampled at the next rising edge, visible at the falling edge after the fifth
        // rising edge from here
        due_q.push_back(run_cycles + latency);
        tag_q.push_back(tag_width'(idx));
    endtask

    task automatic check_response();
        int                   due;
        int                   idx;
        logic [tag_width-1:0] exp_tag;
        due     = due_q.pop_front();
        exp_tag = tag_q.pop_front();
        idx     = int'(exp_tag);
        responses++;
        checks += 4;
        assert (run_cycles == due) else begin
            $display("Error at %0t: tag %0d returned at cycle %0d, expected cycle %0d",
                     $time, exp_tag, run_cycles, due);
            errors++;
        end
        assert (rsp.tag == exp_tag) else begin
            $display("Error at %0t: tag %0d returned, expected tag %0d", $time, rsp.tag, exp_tag);
            errors++;
        end
        assert (rsp.result.raw == vectors[idx].res) else begin
            $display("Error at %0t: tag %0d result %h, expected %h",
                     $time, exp_tag, rsp.result.raw, vectors[idx].res);
            errors++;
        end
        assert (rsp.flags == vectors[idx].flags) else begin
            $display("Error at %0t: tag %0d flags %b, expected %b",
                     $time, exp_tag, rsp.flags, vectors[idx].flags);
            errors++;
        end
    endtask

    // response monitor, outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            checks++;
            assert (!rsp.valid) else begin
                $display("rsp.valid went high during reset at time %0t", $time);
                errors++;
            end
        end else if (rsp.valid) begin
            assert (due_q.size() != 0) else begin
                $display("response with tag %0d at time %0t has no request outstanding",
                         rsp.tag, $time);
                errors++;
            end
            if (due_q.size() != 0) begin
                check_response();
            end
        end else if (due_q.size() != 0) begin
            // oldest request past its slot means a lost response
            assert (due_q[0] > run_cycles) else begin
                $display("no response for tag %0d at time %0t, it was due at cycle %0d",
                         tag_q[0], $time, due_q[0]);
                errors++;
                void'(due_q.pop_front());
                void'(tag_q.pop_front());
            end
        end
    end

    // cycle count and run limit
    always @(posedge clk) begin
        run_cycles = run_cycles + 1;
        if (run_cycles >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d responses still outstanding",
                     run_cycles, due_q.size());
            $display("checks %0d, errors %0d", checks, errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b0;
        req        = '0;
        seed       = 65;
        errors     = 0;
        checks     = 0;
        responses  = 0;
        run_cycles = 0;
        load_vectors();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        // random gaps of 0 to 3 idle cycles, gap 0 gives back-to-back issue
        for (int i = 0; i < num_vectors; i++) begin
            gap = $unsigned($random(seed)) % 4;
            idle_cycles(gap);
            send_request(i);
        end
        idle_cycles(1);
        while (due_q.size() != 0) begin
            @(negedge clk);
        end
        // a few more cycles to catch a duplicated response
        idle_cycles(3);
        checks++;
        assert (responses == num_vectors) else begin
            $display("received %0d responses for %0d requests", responses, num_vectors);
            errors++;
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- fpu_top.sv
// fixed five-cycle latency, one request per cycle accepted, results in request order
module fpu_top
    import fpu_op_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  fpu_req_t req,
    output fpu_rsp_t rsp
);

    // issue -> adder
    add_req_t add_req;
    // adder -> retire
    add_rsp_t add_rsp;

    // flush and sign fold, 1 cycle
    fpu_issue issue_i (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .add_req (add_req)
    );

    // align, add, normalize, 3 cycles
    float_add_pipeline adder_i (
        .clk     (clk),
        .rst     (rst),
        .add_req (add_req),
        .add_rsp (add_rsp)
    );

    // saturate, flush, flags, 1 cycle
    fpu_retire retire_i (
        .clk     (clk),
        .rst     (rst),
        .add_rsp (add_rsp),
        .rsp     (rsp)
    );

endmodule

//--- fpu_retire.sv
// exponent overflow saturates to signed infinity and underflow flushes to signed zero, no traps
module fpu_retire
    import float_pkg::*;
    import fpu_op_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  add_rsp_t add_rsp,
    output fpu_rsp_t rsp
);

    float_word_u final_w;
    fpu_flags_t  flags_n;

    always_comb begin
        final_w = add_rsp.result;
        if (add_rsp.exp_over) begin
            // infinity keeps the sign of the sum
            final_w.fields.exp  = float_exp_max[float_exp_width-1:0];
            final_w.fields.mant = '0;
        end else if (add_rsp.exp_under) begin
            final_w.fields.exp  = '0;
            final_w.fields.mant = '0;
        end
    end

    // flags come from the word actually returned
    always_comb begin
        flags_n.zero      = (final_w.fields.exp == '0) && (final_w.fields.mant == '0);
        flags_n.negative  = final_w.fields.sign;
        flags_n.overflow  = add_rsp.exp_over;
        flags_n.underflow = add_rsp.exp_under;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rsp <= '0;
        end else begin
            rsp.valid <= add_rsp.valid;
            // result is held between strobes
            if (add_rsp.valid) begin
                rsp.tag    <= add_rsp.tag;
                rsp.result <= final_w;
                rsp.flags  <= flags_n;
            end
        end
    end

endmodule

//--- float_add_pipeline.sv
// truncating add of normal operands only, inputs must already be subnormal-flushed
module float_add_pipeline
    import float_pkg::*;
    import fpu_op_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  add_req_t add_req,
    output add_rsp_t add_rsp
);

    typedef logic [mant_ext_width-1:0]         mant_t;
    typedef logic [$clog2(mant_ext_width)-1:0] shift_t;
    // one extra bit so exponent carry and borrow are visible
    typedef logic [float_exp_width:0]          exp_ext_t;

    // align -> add
    typedef struct packed {
        logic                       valid;
        logic [tag_width-1:0]       tag;
        logic                       sign_a;
        logic                       sign_b;
        logic [float_exp_width-1:0] exp;
        mant_t                      mant_a;
        mant_t                      mant_b;
    } align_t;

    // add -> normalize
    typedef struct packed {
        logic                       valid;
        logic [tag_width-1:0]       tag;
        logic                       sign;
        logic [float_exp_width-1:0] exp;
        mant_t                      mant;
    } sum_t;

    align_t   align_n, align_q;
    sum_t     sum_n, sum_q;
    add_rsp_t norm_n;
    mant_t    norm_mant;
    exp_ext_t norm_exp;
    shift_t   norm_shift;

    // distance of the highest set bit below the carry from the hidden-one slot
    function automatic shift_t lead_shift(input mant_t m);
        shift_t s;
        s = '0;
        // ascending scan, the last hit is the highest one
        for (int i = 0; i < mant_ext_width - 1; i++) begin
            if (m[i]) begin
                s = shift_t'(mant_ext_width - 2 - i);
            end
        end
        return s;
    endfunction

    // align stage
    always_comb begin
        align_n.valid  = add_req.valid;
        align_n.tag    = add_req.tag;
        align_n.sign_a = add_req.a.fields.sign;
        align_n.sign_b = add_req.b.fields.sign;
        // hidden one only for a nonzero exponent, a zero operand stays all zero
        align_n.mant_a = {1'b0, add_req.a.fields.exp != '0, add_req.a.fields.mant, 1'b0};
        align_n.mant_b = {1'b0, add_req.b.fields.exp != '0, add_req.b.fields.mant, 1'b0};
        if (add_req.a.fields.exp >= add_req.b.fields.exp) begin
            align_n.exp    = add_req.a.fields.exp;
            align_n.mant_b = align_n.mant_b >> (add_req.a.fields.exp - add_req.b.fields.exp);
        end else begin
            align_n.exp    = add_req.b.fields.exp;
            align_n.mant_a = align_n.mant_a >> (add_req.b.fields.exp - add_req.a.fields.exp);
        end
    end

    // add stage, sign-magnitude
    always_comb begin
        sum_n.valid = align_q.valid;
        sum_n.tag   = align_q.tag;
        sum_n.exp   = align_q.exp;
        if (align_q.sign_a == align_q.sign_b) begin
            sum_n.sign = align_q.sign_a;
            sum_n.mant = align_q.mant_a + align_q.mant_b;
        end else if (align_q.mant_a > align_q.mant_b) begin
            sum_n.sign = align_q.sign_a;
            sum_n.mant = align_q.mant_a - align_q.mant_b;
        end else if (align_q.mant_b > align_q.mant_a) begin
            sum_n.sign = align_q.sign_b;
            sum_n.mant = align_q.mant_b - align_q.mant_a;
        end else begin
            // exact cancellation is +0
            sum_n.sign = 1'b0;
            sum_n.mant = '0;
        end
    end

    // normalize stage
    always_comb begin
        norm_mant        = sum_q.mant;
        norm_exp         = exp_ext_t'(sum_q.exp);
        norm_shift       = '0;
        norm_n.valid     = sum_q.valid;
        norm_n.tag       = sum_q.tag;
        norm_n.exp_under = 1'b0;
        if (sum_q.mant[mant_ext_width-1]) begin
            // carry out, one step right
            norm_mant = sum_q.mant >> 1;
            norm_exp  = norm_exp + 1'b1;
        end else if (sum_q.mant != '0) begin
            norm_shift       = lead_shift(sum_q.mant);
            norm_mant        = sum_q.mant << norm_shift;
            norm_n.exp_under = exp_ext_t'(norm_shift) >= norm_exp;
            norm_exp         = norm_exp - exp_ext_t'(norm_shift);
        end
        norm_n.exp_over = !norm_n.exp_under && (norm_exp >= exp_ext_t'(float_exp_max));
        // guard bit dropped here, plain truncation
        norm_n.result.fields.sign = sum_q.sign;
        norm_n.result.fields.exp  = norm_exp[float_exp_width-1:0];
        norm_n.result.fields.mant = norm_mant[float_mant_width:1];
        if (sum_q.mant == '0) begin
            norm_n.result.raw = '0;
        end
    end

    // three register ranks, valid and tag ride along
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            align_q <= '0;
            sum_q   <= '0;
            add_rsp <= '0;
        end else begin
            align_q <= align_n;
            sum_q   <= sum_n;
            add_rsp <= norm_n;
        end
    end

endmodule

//--- fpu_issue.sv
// no back-pressure, a strobe is taken every cycle; subnormals become signed zeros
module fpu_issue
    import float_pkg::*;
    import fpu_op_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  fpu_req_t req,
    output add_req_t add_req
);

    float_word_u a_flush;
    float_word_u b_flush;

    // zero exponent means zero or subnormal, keep only the sign
    function automatic float_word_u flush_sub(input float_word_u w);
        float_word_u f;
        f = w;
        if (w.fields.exp == '0) begin
            f.fields.mant = '0;
        end
        return f;
    endfunction

    always_comb begin
        a_flush = flush_sub(req.a);
        b_flush = flush_sub(req.b);
        // a - b is a + (-b), adder never sees an opcode
        if (req.op == op_sub) begin
            b_flush.fields.sign = ~b_flush.fields.sign;
        end
    end

    // one register rank
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            add_req <= '0;
        end else begin
            add_req.valid <= req.valid;
            // payload only moves on a strobe, held otherwise
            if (req.valid) begin
                add_req.tag <= req.tag;
                add_req.a   <= a_flush;
                add_req.b   <= b_flush;
            end
        end
    end

endmodule

//--- fpu_op_pkg.sv
// request/response records of the add unit; tags are opaque and only carried through
package fpu_op_pkg;

    import float_pkg::*;

    localparam int tag_width = 4;

    // subtract is folded into add at issue
    typedef enum logic {
        op_add = 1'b0,
        op_sub = 1'b1
    } fpu_op_e;

    // request from outside, valid is a one-cycle strobe
    typedef struct packed {
        logic                 valid;
        fpu_op_e              op;
        logic [tag_width-1:0] tag;
        float_word_u          a;
        float_word_u          b;
    } fpu_req_t;

    // operands after subnormal flush and sign fold
    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] tag;
        float_word_u          a;
        float_word_u          b;
    } add_req_t;

    // raw adder result, exponent range still unchecked
    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] tag;
        float_word_u          result;
        logic                 exp_over;
        logic                 exp_under;
    } add_rsp_t;

    typedef struct packed {
        logic zero;
        logic negative;
        logic overflow;
        logic underflow;
    } fpu_flags_t;

    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] tag;
        float_word_u          result;
        fpu_flags_t           flags;
    } fpu_rsp_t;

endpackage

//--- float_pkg.sv
// single-precision format only; no NaN/inf classes here, exp 255 is just a large exponent
package float_pkg;

    // word layout
    localparam int float_width      = 32;
    localparam int float_exp_width  = 8;
    localparam int float_mant_width = 23;

    // all-ones exponent, reached by saturation only
    localparam int float_exp_max = 255;

    // working mantissa inside the adder
    // [overflow][hidden one][stored mantissa][guard]
    localparam int mant_ext_width = float_mant_width + 3;

    // sign / exponent / mantissa view of a word
    typedef struct packed {
        logic                        sign;
        logic [float_exp_width-1:0]  exp;
        logic [float_mant_width-1:0] mant;
    } float_fields_t;

    // same 32 bits, either as a raw bus word or split into fields
    // raw is what travels on the ports, fields is what the datapath decodes
    typedef union packed {
        logic [float_width-1:0] raw;
        float_fields_t          fields;
    } float_word_u;

endpackage
